/* verilog/tinker_defs.svh */
// Word widths, register and memory sizes, reset PC and initial stack pointer
`ifndef TINKER_DEFS_SVH
`define TINKER_DEFS_SVH

// Datapath word and instruction width
`define TINKER_XLEN 64
`define TINKER_ILEN 32

// Register file
`define TINKER_NREGS  32
`define TINKER_SP_REG 5'd31   // Stack pointer used by call and return

// Byte-addressed data and program memory
`define TINKER_MEM_BYTES 65536

// First instruction fetched after reset
`define TINKER_RESET_PC 32'h0000_2000

// Top of stack held in r31 after reset
`define TINKER_STACK_INIT 64'h0000_0000_0001_0000

`endif

/* verilog/tinker_pkg.sv */
// Opcode and sequencer state enums shared by the Tinker core
`default_nettype none

package tinker_pkg;

    // Opcode field, instr[31:27]
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,   // Absolute jump to rd
        OP_BRR_RD = 5'h09,   // PC relative by rd
        OP_BRR_L  = 5'h0a,   // PC relative by signed L
        OP_BRNZ   = 5'h0b,
        OP_CALL   = 5'h0c,
        OP_RET    = 5'h0d,
        OP_BRGT   = 5'h0e,
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,
        OP_MOV    = 5'h11,
        OP_MOVL   = 5'h12,   // Literal into low 12 bits of rd
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    // Multicycle sequence, HALTED is terminal until reset
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } state_t;

endpackage

`default_nettype wire

/* verilog/tinker_ifs.sv */
// Data memory port and register file port interfaces
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

// 64-bit load and store port between control and memory
interface mem_data_if;
    logic [31:0]             load_addr;
    logic [`TINKER_XLEN-1:0] load_data;    // Combinational read
    logic                    store_we;
    logic [31:0]             store_addr;
    logic [`TINKER_XLEN-1:0] store_data;

    modport master (
        output load_addr, store_we, store_addr, store_data,
        input  load_data
    );

    modport slave (
        input  load_addr, store_we, store_addr, store_data,
        output load_data
    );
endinterface

// Two read ports and one write port into the register file
interface reg_port_if;
    logic [4:0]              addr_a;
    logic [4:0]              addr_b;
    logic [`TINKER_XLEN-1:0] data_a;
    logic [`TINKER_XLEN-1:0] data_b;
    logic                    we;
    logic [4:0]              wr_addr;
    logic [`TINKER_XLEN-1:0] wr_data;

    modport master (
        output addr_a, addr_b, we, wr_addr, wr_data,
        input  data_a, data_b
    );

    modport slave (
        input  addr_a, addr_b, we, wr_addr, wr_data,
        output data_a, data_b
    );
endinterface

`default_nettype wire

/* verilog/memory.sv */
// Big-endian byte memory with fetch, data and program-load ports
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module memory #(
    parameter int mem_bytes = `TINKER_MEM_BYTES
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_word,
    mem_data_if.slave   data,
    input  logic        prog_we,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_data
);
    localparam int aw = $clog2(mem_bytes);

    logic [7:0] bytes [mem_bytes];

    // Instruction fetch, most significant byte at the lowest address
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            fetch_word[31-8*k -: 8] = bytes[aw'(fetch_addr + 32'(k))];
        end
    end

    // 8-byte data load
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            data.load_data[`TINKER_XLEN-1-8*k -: 8] = bytes[aw'(data.load_addr + 32'(k))];
        end
    end

    always_ff @(posedge clk) begin
        if (reset && prog_we) begin // Program image goes in only while the core is held
            for (int k = 0; k < 4; k++) begin
                bytes[aw'(prog_addr + 32'(k))] <= prog_data[31-8*k -: 8];
            end
        end else if (data.store_we) begin
            for (int k = 0; k < 8; k++) begin
                bytes[aw'(data.store_addr + 32'(k))] <= data.store_data[`TINKER_XLEN-1-8*k -: 8];
            end
        end
    end

    // Whole 8-byte store lands inside the array
    store_in_range: assert property (
        @(posedge clk) disable iff (reset)
        data.store_we |-> ({32'b0, data.store_addr} + 64'd7 < 64'(mem_bytes))
    );

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
// 32 x 64-bit register file with two operand read ports, a debug read port and one write port
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    reg_port_if.slave               port,
    input  logic [4:0]              dbg_addr,
    output logic [`TINKER_XLEN-1:0] dbg_data
);
    logic [`TINKER_XLEN-1:0] regs [`TINKER_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS; i++) begin
                regs[i] <= '0;
            end
            regs[`TINKER_SP_REG] <= `TINKER_STACK_INIT; // Stack starts at top of memory
        end else if (port.we) begin
            regs[port.wr_addr] <= port.wr_data;
        end
    end

    // Combinational reads, old value seen during the write cycle
    assign port.data_a = regs[port.addr_a];
    assign port.data_b = regs[port.addr_b];
    assign dbg_data    = regs[dbg_addr];   // Observation only

endmodule

`default_nettype wire

/* verilog/alu.sv */
// Combinational integer ALU with logic, shift and move operations
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module alu
    import tinker_pkg::*;
(
    input  opcode_t                 op,
    input  logic [`TINKER_XLEN-1:0] op_a,
    input  logic [`TINKER_XLEN-1:0] op_b,
    input  logic [11:0]             lit,
    output logic [`TINKER_XLEN-1:0] result
);
    logic [`TINKER_XLEN-1:0] lit_ext;

    assign lit_ext = {{(`TINKER_XLEN-12){1'b0}}, lit}; // Zero-extended literal

    always_comb begin
        case (op)
            OP_ADD:    result = op_a + op_b;
            OP_ADDI:   result = op_a + lit_ext;
            OP_SUB:    result = op_a - op_b;
            OP_SUBI:   result = op_a - lit_ext;
            OP_MUL:    result = op_a * op_b;     // Low 64 bits of the product
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            OP_SHFTR:  result = op_a >> op_b;    // Logical shifts
            OP_SHFTRI: result = op_a >> lit_ext;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTLI: result = op_a << lit_ext;
            OP_MOV:    result = op_a;
            // Upper bits of rd survive
            OP_MOVL:   result = {op_a[`TINKER_XLEN-1:12], lit};
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/control.sv */
// Instruction decode, operand routing, branch targets, data memory access and result register
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module control
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  state_t                  state,
    input  logic [31:0]             pc,
    input  logic [`TINKER_ILEN-1:0] instr,
    input  logic [`TINKER_XLEN-1:0] alu_result,
    output logic [31:0]             next_pc,
    output opcode_t                 op,
    output logic [`TINKER_XLEN-1:0] op_a,
    output logic [`TINKER_XLEN-1:0] op_b,
    output logic [11:0]             lit,
    reg_port_if.master              regs,
    mem_data_if.master              mem
);
    logic [4:0]              rd;
    logic [4:0]              rs;
    logic [4:0]              rt;
    logic [`TINKER_XLEN-1:0] result;     // ALU result, or load data after MEMORY
    logic                    gt_taken;   // brgt outcome
    logic [31:0]             pc_plus4;
    logic [31:0]             offset_addr;
    logic [31:0]             stack_slot;
    logic                    writes_reg;

    assign op   = opcode_t'(instr[31:27]);
    assign rd   = instr[26:22];
    assign rs   = instr[21:17];
    assign rt   = instr[16:12];
    assign lit  = instr[11:0];
    assign op_a = regs.data_a;
    assign op_b = regs.data_b;

    // Read addresses default to rs and rt unless the opcode needs rd or the stack pointer
    always_comb begin
        regs.addr_a = rs;
        regs.addr_b = rt;
        case (op)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOVL: regs.addr_a = rd;
            OP_BR, OP_BRR_RD: regs.addr_a = rd;
            OP_BRNZ: regs.addr_b = rd;
            // Port B holds rt for the compare in DECODE, then the target rd
            OP_BRGT: regs.addr_b = (state == DECODE) ? rt : rd;
            OP_CALL: begin
                regs.addr_a = rd;
                regs.addr_b = `TINKER_SP_REG;
            end
            OP_RET: regs.addr_a = `TINKER_SP_REG;
            OP_STORE: begin
                regs.addr_a = rd;   // Base
                regs.addr_b = rs;   // Value
            end
            default: ;
        endcase
    end

    assign pc_plus4    = pc + 32'd4;
    assign offset_addr = regs.data_a[31:0] + {20'b0, lit};
    assign stack_slot  = (op == OP_CALL) ? regs.data_b[31:0] - 32'd8
                                         : regs.data_a[31:0] - 32'd8;

    // Taken in WRITEBACK only
    always_comb begin
        case (op)
            OP_BR:     next_pc = regs.data_a[31:0];
            OP_BRR_RD: next_pc = pc + regs.data_a[31:0];
            OP_BRR_L:  next_pc = pc + {{20{lit[11]}}, lit};
            OP_BRNZ:   next_pc = (regs.data_a != '0) ? regs.data_b[31:0] : pc_plus4;
            OP_BRGT:   next_pc = gt_taken ? regs.data_b[31:0] : pc_plus4;
            OP_CALL:   next_pc = regs.data_a[31:0];
            OP_RET:    next_pc = result[31:0];   // Return address read from the stack slot
            default:   next_pc = pc_plus4;
        endcase
    end

    assign mem.load_addr  = (op == OP_RET) ? stack_slot : offset_addr;
    assign mem.store_we   = (state == MEMORY) && (op == OP_STORE || op == OP_CALL);
    assign mem.store_addr = (op == OP_CALL) ? stack_slot : offset_addr;
    assign mem.store_data = (op == OP_CALL) ? {{(`TINKER_XLEN-32){1'b0}}, pc_plus4}
                                            : regs.data_b;

    assign writes_reg = op inside {OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTRI,
                                   OP_SHFTL, OP_SHFTLI, OP_MOV, OP_MOVL, OP_LOAD,
                                   OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL};

    assign regs.we      = (state == WRITEBACK) && writes_reg;
    assign regs.wr_addr = rd;
    assign regs.wr_data = result;

    // Signed compare of rs against rt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gt_taken <= 1'b0;
        end else if (state == DECODE) begin
            gt_taken <= $signed(regs.data_a) > $signed(regs.data_b);
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXECUTE) begin
            result <= alu_result;
        end else if (state == MEMORY && (op == OP_LOAD || op == OP_RET)) begin
            result <= mem.load_data;
        end
    end

    // An instruction that stores never writes a register in its WRITEBACK step
    store_write_excl: assert property (
        @(posedge clk) disable iff (reset) mem.store_we |=> !regs.we
    );

endmodule

`default_nettype wire

/* verilog/sequencer.sv */
// Five-state sequencer with PC, instruction register and registered halt flag
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module sequencer
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`TINKER_ILEN-1:0] fetch_word,
    input  logic [31:0]             next_pc,
    output state_t                  state,
    output logic [31:0]             pc,
    output logic [`TINKER_ILEN-1:0] instr,
    output logic                    hlt
);
    logic is_halt;

    assign is_halt = (opcode_t'(instr[31:27]) == OP_HALT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `TINKER_RESET_PC;
            hlt   <= 1'b0;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE: begin
                    if (is_halt) begin
                        state <= HALTED;
                        hlt   <= 1'b1;   // Held until reset
                    end else begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: state <= MEMORY;
                MEMORY:  state <= WRITEBACK;
                WRITEBACK: begin
                    pc    <= next_pc; // One PC update per instruction
                    state <= FETCH;
                end
                HALTED:  state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    // Instruction word captured at the end of FETCH
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            instr <= fetch_word;
        end
    end

    legal_state: assert property (
        @(posedge clk) disable iff (reset)
        state inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALTED}
    );

endmodule

`default_nettype wire

/* verilog/tinker_core.sv */
// Tinker core top level joining sequencer, control, ALU, register file and memory
`timescale 1ns/1ps
`default_nettype none
`include "tinker_defs.svh"

module tinker_core
    import tinker_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    output logic                    hlt,
    input  logic                    prog_we,
    input  logic [31:0]             prog_addr,
    input  logic [31:0]             prog_data,
    input  logic [4:0]              dbg_addr,
    output logic [`TINKER_XLEN-1:0] dbg_data
);
    state_t                  state;
    opcode_t                 op;
    logic [31:0]             pc;
    logic [31:0]             next_pc;
    logic [`TINKER_ILEN-1:0] instr;
    logic [`TINKER_ILEN-1:0] fetch_word;
    logic [`TINKER_XLEN-1:0] op_a;
    logic [`TINKER_XLEN-1:0] op_b;
    logic [`TINKER_XLEN-1:0] alu_result;
    logic [11:0]             lit;

    mem_data_if mem_bus ();
    reg_port_if reg_bus ();

    sequencer u_sequencer (
        .clk(clk), .reset(reset), .fetch_word(fetch_word), .next_pc(next_pc),
        .state(state), .pc(pc), .instr(instr), .hlt(hlt)
    );

    control u_control (
        .clk(clk), .reset(reset), .state(state), .pc(pc), .instr(instr),
        .alu_result(alu_result), .next_pc(next_pc), .op(op), .op_a(op_a),
        .op_b(op_b), .lit(lit), .regs(reg_bus.master), .mem(mem_bus.master)
    );

    alu u_alu (.op(op), .op_a(op_a), .op_b(op_b), .lit(lit), .result(alu_result));

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .port(reg_bus.slave),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    memory #(.mem_bytes(`TINKER_MEM_BYTES)) u_memory (
        .clk(clk), .reset(reset), .fetch_addr(pc), .fetch_word(fetch_word),
        .data(mem_bus.slave), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data)
    );

endmodule

`default_nettype wire

/* tests/tinker_tb_tasks.svh */
// Instruction encoding, program building, reset with program load, run to halt and register check
`ifndef TINKER_TB_TASKS_SVH
`define TINKER_TB_TASKS_SVH

// Fields: opcode 31..27, rd 26..22, rs 21..17, rt 16..12, L 11..0
function automatic logic [31:0] encode(input opcode_t op, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [11:0] lit);
    return {op, rd, rs, rt, lit};
endfunction

task automatic clear_program;
    prog_words.delete();
endtask

task automatic emit(input opcode_t op, input logic [4:0] rd, input logic [4:0] rs,
                    input logic [4:0] rt, input logic [11:0] lit);
    prog_words.push_back(encode(op, rd, rs, rt, lit));
endtask

// Holds reset for at least reset_cycles, longer if the program needs more load cycles
task automatic reset_and_load;
    int n;
    n = (prog_words.size() > reset_cycles) ? prog_words.size() : reset_cycles;
    reset = 1'b1;
    for (int i = 0; i < n; i++) begin
        prog_we   = (i < prog_words.size());
        prog_addr = prog_base + 32'(4 * i);   // One word per cycle
        prog_data = (i < prog_words.size()) ? prog_words[i] : 32'd0;
        @(posedge clk);
        #1;
    end
    prog_we = 1'b0;
    reset   = 1'b0;
endtask

// Counts rising edges from reset release until hlt
task automatic run_to_halt(input string name, output int cycles);
    cycles = 0;
    while (hlt !== 1'b1) begin
        if (cycles >= max_cycles) begin
            $display("Timeout in %s: hlt did not rise within %0d cycles", name, max_cycles);
            $display("Result: FAILED");
            $fatal(1, "halt timeout in %s", name);
        end
        @(posedge clk);
        #1;
        cycles++;
    end
endtask

task automatic expect_reg(input string name, input logic [4:0] r, input logic [63:0] expected);
    @(posedge clk);
    #1;
    dbg_addr = r;
    #1;   // Debug read is combinational
    check_eq($sformatf("%s r%0d", name, r), expected, dbg_data);
endtask

`endif

/* tests/tinker_core_tb.sv */
// Testbench for the Tinker core with clock, reset, DUT, value check and directed tests
`timescale 1ns/1ps
`default_nettype none

module tinker_core_tb
    import tinker_pkg::*;
();
    localparam logic [31:0] prog_base    = 32'h0000_2000;
    localparam logic [63:0] stack_init   = 64'h0000_0000_0001_0000;
    localparam int          reset_cycles = 8;
    localparam int          max_cycles   = 2000;

    logic        clk;
    logic        reset;
    logic        hlt;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;
    logic [31:0] prog_words [$];   // Image loaded from prog_base up

    tinker_core dut (
        .clk(clk), .reset(reset), .hlt(hlt), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s]: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    `include "tinker_tb_tasks.svh"

    task automatic reset_halt_test;
        string name;
        int    cycles;
        name = "reset_halt";
        clear_program();
        emit(OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
        reset_and_load();
        check_eq(name, 64'd0, {63'd0, hlt});
        run_to_halt(name, cycles);
        check_eq(name, 64'd2, 64'(cycles));   // FETCH then DECODE
        for (int r = 0; r < 31; r++) begin
            expect_reg(name, 5'(r), 64'd0);
        end
        expect_reg(name, 5'd31, stack_init);
        repeat (10) begin
            @(posedge clk);
            #1;
            check_eq(name, 64'd1, {63'd0, hlt});
        end
    endtask

    task automatic alu_ops_test;
        string       name;
        int          cycles;
        logic [11:0] a, b, c, d, e;
        logic [5:0]  s, s2;
        logic [63:0] x, y;
        name = "alu_ops";
        a  = 12'($urandom);
        b  = 12'($urandom);
        c  = 12'($urandom);
        d  = 12'($urandom);
        e  = 12'($urandom);
        s  = 6'($urandom);
        s2 = 6'($urandom);
        x  = ({52'd0, a} << 36) + {52'd0, c};
        y  = ({52'd0, b} << 20) - {52'd0, d};
        clear_program();
        emit(OP_MOVL,   5'd1,  5'd0, 5'd0, a);
        emit(OP_SHFTLI, 5'd1,  5'd0, 5'd0, 12'd36);
        emit(OP_ADDI,   5'd1,  5'd0, 5'd0, c);
        emit(OP_MOVL,   5'd2,  5'd0, 5'd0, b);
        emit(OP_SHFTLI, 5'd2,  5'd0, 5'd0, 12'd20);
        emit(OP_SUBI,   5'd2,  5'd0, 5'd0, d);
        emit(OP_MOVL,   5'd3,  5'd0, 5'd0, {6'd0, s});   // Shift amount register
        emit(OP_ADD,    5'd4,  5'd1, 5'd2, 12'd0);
        emit(OP_SUB,    5'd5,  5'd1, 5'd2, 12'd0);
        emit(OP_MUL,    5'd6,  5'd1, 5'd2, 12'd0);
        emit(OP_AND,    5'd7,  5'd1, 5'd2, 12'd0);
        emit(OP_OR,     5'd8,  5'd1, 5'd2, 12'd0);
        emit(OP_XOR,    5'd9,  5'd1, 5'd2, 12'd0);
        emit(OP_NOT,    5'd10, 5'd1, 5'd0, 12'd0);
        emit(OP_SHFTR,  5'd11, 5'd1, 5'd3, 12'd0);
        emit(OP_SHFTL,  5'd12, 5'd2, 5'd3, 12'd0);
        emit(OP_MOV,    5'd13, 5'd1, 5'd0, 12'd0);
        emit(OP_SHFTRI, 5'd13, 5'd0, 5'd0, {6'd0, s2});
        emit(OP_MOV,    5'd14, 5'd2, 5'd0, 12'd0);
        emit(OP_SHFTLI, 5'd14, 5'd0, 5'd0, {6'd0, s2});
        emit(OP_MOV,    5'd15, 5'd1, 5'd0, 12'd0);
        emit(OP_ADDI,   5'd15, 5'd0, 5'd0, e);
        emit(OP_MOV,    5'd16, 5'd2, 5'd0, 12'd0);
        emit(OP_SUBI,   5'd16, 5'd0, 5'd0, e);
        emit(OP_HALT,   5'd0,  5'd0, 5'd0, 12'd0);
        reset_and_load();
        run_to_halt(name, cycles);
        check_eq(name, 64'(5 * 24 + 2), 64'(cycles));
        expect_reg(name, 5'd1,  x);
        expect_reg(name, 5'd2,  y);
        expect_reg(name, 5'd3,  {58'd0, s});
        expect_reg(name, 5'd4,  x + y);
        expect_reg(name, 5'd5,  x - y);
        expect_reg(name, 5'd6,  x * y);
        expect_reg(name, 5'd7,  x & y);
        expect_reg(name, 5'd8,  x | y);
        expect_reg(name, 5'd9,  x ^ y);
        expect_reg(name, 5'd10, ~x);
        expect_reg(name, 5'd11, x >> s);
        expect_reg(name, 5'd12, y << s);
        expect_reg(name, 5'd13, x >> s2);
        expect_reg(name, 5'd14, y << s2);
        expect_reg(name, 5'd15, x + {52'd0, e});
        expect_reg(name, 5'd16, y - {52'd0, e});
    endtask

    task automatic move_test;
        string       name;
        int          cycles;
        logic [11:0] a, b, c;
        logic [63:0] m;
        name = "moves";
        a = 12'($urandom);
        b = 12'($urandom);
        c = 12'($urandom);
        m = ({52'd0, a} << 16) + {52'd0, c};
        m = {m[63:12], b};   // Upper bits kept
        clear_program();
        emit(OP_MOVL,   5'd1, 5'd0,  5'd0, a);
        emit(OP_SHFTLI, 5'd1, 5'd0,  5'd0, 12'd16);
        emit(OP_ADDI,   5'd1, 5'd0,  5'd0, c);
        emit(OP_MOVL,   5'd1, 5'd0,  5'd0, b);
        emit(OP_NOT,    5'd4, 5'd0,  5'd0, 12'd0);
        emit(OP_MOVL,   5'd4, 5'd0,  5'd0, b);
        emit(OP_MOV,    5'd2, 5'd1,  5'd0, 12'd0);
        emit(OP_MOV,    5'd3, 5'd31, 5'd0, 12'd0);
        emit(OP_HALT,   5'd0, 5'd0,  5'd0, 12'd0);
        reset_and_load();
        run_to_halt(name, cycles);
        check_eq(name, 64'(5 * 8 + 2), 64'(cycles));
        expect_reg(name, 5'd1, m);
        expect_reg(name, 5'd2, m);
        expect_reg(name, 5'd3, stack_init);
        expect_reg(name, 5'd4, {52'hf_ffff_ffff_ffff, b});
        expect_reg(name, 5'd0, 64'd0);
    endtask

    task automatic load_store_test;
        string       name;
        int          cycles;
        logic [11:0] a, b;
        logic [63:0] v;
        name = "load_store";
        a = 12'($urandom);
        b = 12'($urandom);
        v = ~(({52'd0, a} << 40) + {52'd0, b});
        clear_program();
        emit(OP_MOVL,   5'd1, 5'd0, 5'd0, 12'h100);   // Base below the program
        emit(OP_MOVL,   5'd2, 5'd0, 5'd0, a);
        emit(OP_SHFTLI, 5'd2, 5'd0, 5'd0, 12'd40);
        emit(OP_ADDI,   5'd2, 5'd0, 5'd0, b);
        emit(OP_NOT,    5'd2, 5'd2, 5'd0, 12'd0);
        emit(OP_STORE,  5'd1, 5'd2, 5'd0, 12'h048);
        emit(OP_LOAD,   5'd3, 5'd1, 5'd0, 12'h048);
        emit(OP_MOVL,   5'd4, 5'd0, 5'd0, 12'h140);   // Same byte address through another base
        emit(OP_LOAD,   5'd5, 5'd4, 5'd0, 12'h008);
        emit(OP_MOVL,   5'd6, 5'd0, 5'd0, 12'h200);
        emit(OP_SHFTLI, 5'd6, 5'd0, 5'd0, 12'd4);
        emit(OP_LOAD,   5'd7, 5'd6, 5'd0, 12'd0);     // First two program words
        emit(OP_HALT,   5'd0, 5'd0, 5'd0, 12'd0);
        reset_and_load();
        run_to_halt(name, cycles);
        check_eq(name, 64'(5 * 12 + 2), 64'(cycles));
        expect_reg(name, 5'd3, v);
        expect_reg(name, 5'd5, v);
        expect_reg(name, 5'd7, {prog_words[0], prog_words[1]});   // Big-endian
    endtask

    task automatic branch_test;
        string name;
        int    cycles;
        name = "branches";
        clear_program();
        emit(OP_MOVL,   5'd1,  5'd0,  5'd0, 12'd1);     // 0  marker
        emit(OP_BRR_L,  5'd0,  5'd0,  5'd0, 12'd8);     // 1  to 3
        emit(OP_MOVL,   5'd1,  5'd0,  5'd0, 12'hbad);   // 2
        emit(OP_MOVL,   5'd2,  5'd0,  5'd0, 12'h222);   // 3
        emit(OP_MOVL,   5'd20, 5'd0,  5'd0, 12'h200);   // 4
        emit(OP_SHFTLI, 5'd20, 5'd0,  5'd0, 12'd4);     // 5  r20 holds prog_base
        emit(OP_MOV,    5'd21, 5'd20, 5'd0, 12'd0);     // 6
        emit(OP_ADDI,   5'd21, 5'd0,  5'd0, 12'd40);    // 7  word 10
        emit(OP_BRNZ,   5'd21, 5'd0,  5'd0, 12'd0);     // 8  zero test falls through
        emit(OP_MOVL,   5'd3,  5'd0,  5'd0, 12'h333);   // 9
        emit(OP_MOV,    5'd22, 5'd20, 5'd0, 12'd0);     // 10
        emit(OP_ADDI,   5'd22, 5'd0,  5'd0, 12'd56);    // 11 word 14
        emit(OP_BRNZ,   5'd22, 5'd1,  5'd0, 12'd0);     // 12 taken
        emit(OP_MOVL,   5'd4,  5'd0,  5'd0, 12'hbad);   // 13
        emit(OP_NOT,    5'd5,  5'd0,  5'd0, 12'd0);     // 14 r5 = -1
        emit(OP_MOVL,   5'd6,  5'd0,  5'd0, 12'd1);     // 15
        emit(OP_MOV,    5'd23, 5'd20, 5'd0, 12'd0);     // 16
        emit(OP_ADDI,   5'd23, 5'd0,  5'd0, 12'd84);    // 17 word 21
        emit(OP_BRGT,   5'd23, 5'd6,  5'd5, 12'd0);     // 18 1 > -1 only when signed
        emit(OP_MOVL,   5'd7,  5'd0,  5'd0, 12'hbad);   // 19
        emit(OP_MOVL,   5'd7,  5'd0,  5'd0, 12'hbad);   // 20
        emit(OP_MOV,    5'd24, 5'd20, 5'd0, 12'd0);     // 21
        emit(OP_ADDI,   5'd24, 5'd0,  5'd0, 12'd100);   // 22 word 25
        emit(OP_BRGT,   5'd24, 5'd5,  5'd6, 12'd0);     // 23 not taken
        emit(OP_MOVL,   5'd8,  5'd0,  5'd0, 12'h888);   // 24
        emit(OP_MOV,    5'd25, 5'd20, 5'd0, 12'd0);     // 25
        emit(OP_ADDI,   5'd25, 5'd0,  5'd0, 12'd116);   // 26 word 29
        emit(OP_BR,     5'd25, 5'd0,  5'd0, 12'd0);     // 27
        emit(OP_MOVL,   5'd9,  5'd0,  5'd0, 12'hbad);   // 28
        emit(OP_MOVL,   5'd10, 5'd0,  5'd0, 12'haaa);   // 29
        emit(OP_HALT,   5'd0,  5'd0,  5'd0, 12'd0);     // 30
        reset_and_load();
        run_to_halt(name, cycles);
        check_eq(name, 64'(5 * 25 + 2), 64'(cycles));   // Five words skipped
        expect_reg(name, 5'd1,  64'd1);
        expect_reg(name, 5'd2,  64'h222);
        expect_reg(name, 5'd3,  64'h333);
        expect_reg(name, 5'd4,  64'd0);
        expect_reg(name, 5'd7,  64'd0);
        expect_reg(name, 5'd8,  64'h888);
        expect_reg(name, 5'd9,  64'd0);
        expect_reg(name, 5'd10, 64'haaa);
    endtask

    task automatic call_return_test;
        string name;
        int    cycles;
        name = "call_return";
        clear_program();
        emit(OP_MOVL,   5'd20, 5'd0,  5'd0, 12'h200);   // 0
        emit(OP_SHFTLI, 5'd20, 5'd0,  5'd0, 12'd4);     // 1
        emit(OP_MOV,    5'd21, 5'd20, 5'd0, 12'd0);     // 2
        emit(OP_ADDI,   5'd21, 5'd0,  5'd0, 12'd40);    // 3  subroutine at word 10
        emit(OP_CALL,   5'd21, 5'd0,  5'd0, 12'd0);     // 4
        emit(OP_MOVL,   5'd2,  5'd0,  5'd0, 12'h555);   // 5  return lands here
        emit(OP_MOV,    5'd4,  5'd31, 5'd0, 12'd0);     // 6
        emit(OP_SUBI,   5'd4,  5'd0,  5'd0, 12'd8);     // 7
        emit(OP_LOAD,   5'd3,  5'd4,  5'd0, 12'd0);     // 8  stack slot contents
        emit(OP_HALT,   5'd0,  5'd0,  5'd0, 12'd0);     // 9
        emit(OP_MOVL,   5'd1,  5'd0,  5'd0, 12'h111);   // 10
        emit(OP_RET,    5'd0,  5'd0,  5'd0, 12'd0);     // 11
        reset_and_load();
        run_to_halt(name, cycles);
        check_eq(name, 64'(5 * 11 + 2), 64'(cycles));
        expect_reg(name, 5'd1,  64'h111);
        expect_reg(name, 5'd2,  64'h555);
        expect_reg(name, 5'd3,  {32'd0, prog_base + 32'd20});
        expect_reg(name, 5'd4,  stack_init - 64'd8);
        expect_reg(name, 5'd31, stack_init);
    endtask

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = 32'd0;
        prog_data = 32'd0;
        dbg_addr  = 5'd0;
        void'($urandom(32'h7d60bb03));
        @(posedge clk);
        #1;
        reset_halt_test();
        alu_ops_test();
        move_test();
        load_store_test();
        branch_test();
        call_return_test();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
+incdir+tests
verilog/tinker_pkg.sv
verilog/tinker_ifs.sv
verilog/memory.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/control.sv
verilog/sequencer.sv
verilog/tinker_core.sv
tests/tinker_core_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tinker_core_tb
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
